// File: hdl/filter_cfg_pkg.sv
// Filter condition loader definitions
`default_nettype none

package filter_cfg_pkg;

    // ----------------------------------------
    // Widths and sizes
    // ----------------------------------------
    localparam int DATA_W      = 32;
    localparam int OFFSET_W    = 16;
    localparam int SHIFT_W     = 4;
    localparam int NUM_FIELDS  = 4;
    localparam int CFG_WORDS   = 8;
    localparam int FIFO_DEPTH  = 16;
    localparam int PROG_THRESH = 8;
    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

    // ----------------------------------------
    // Plain vector types
    // ----------------------------------------
    typedef logic [DATA_W-1:0]                data_word_t;
    typedef logic [OFFSET_W-1:0]              seq_index_t;
    typedef logic [NUM_FIELDS-1:0]            field_mask_t;
    typedef logic [NUM_FIELDS*NUM_FIELDS-1:0] ops_mask_t;
    typedef logic [3:0]                       cu_id_t;
    typedef logic [3:0]                       bundle_id_t;
    typedef logic [3:0]                       lane_id_t;
    typedef logic [3:0]                       buffer_id_t;
    typedef logic [FIFO_ADDR_W-1:0]           fifo_ptr_t;
    // One extra bit so a full FIFO is distinct from an empty one
    typedef logic [FIFO_ADDR_W:0]             fifo_count_t;

    // ----------------------------------------
    // Encodings
    // ----------------------------------------
    typedef enum logic [1:0] {
        CLASS_NONE,
        CLASS_DATA,
        CLASS_CU_SETUP,
        CLASS_ENGINE_SETUP
    } setup_class_t;

    typedef enum logic [2:0] {
        FOP_EQ,
        FOP_NE,
        FOP_LT,
        FOP_LE,
        FOP_GT,
        FOP_GE,
        FOP_NOP
    } filter_op_t;

    // ----------------------------------------
    // Records
    // ----------------------------------------
    typedef struct packed {
        cu_id_t     cu;
        bundle_id_t bundle;
        lane_id_t   lane;
        buffer_id_t buffer;
    } route_id_t;

    // Memory response as seen by the engine
    typedef struct packed {
        setup_class_t         setup_class;
        seq_index_t           offset;
        logic [SHIFT_W-1:0]   shift_amount;
        data_word_t           data;
    } mem_packet_t;

    typedef struct packed {
        filter_op_t  filter_op;
        field_mask_t filter_mask;
        field_mask_t const_mask;
        data_word_t  const_value;
        ops_mask_t   ops_mask;
        logic        break_flag;
        logic        continue_flag;
        logic        ternary_flag;
        logic        conditional_flag;
        route_id_t   if_route;
        route_id_t   else_route;
    } filter_cond_cfg_t;

    // Sequence index of a packet, offset scaled down by its shift
    function automatic seq_index_t seq_index_of(input mem_packet_t pkt);
        return pkt.offset >> pkt.shift_amount;
    endfunction

endpackage

`default_nettype wire

// File: hdl/cfg_fifo_sync.sv
// Synchronous FIFO with registered read
`timescale 1ns/1ps
`default_nettype none

module cfg_fifo_sync #(
    parameter int unsigned width = 8
) (
    input  wire logic             ap_clk,
    input  wire logic             rst_n,
    input  wire logic             wr_en,
    input  wire logic [width-1:0] din,
    input  wire logic             rd_en,
    output logic      [width-1:0] dout,
    output logic                  rd_valid,
    output logic                  empty,
    output logic                  almost_full
);
    import filter_cfg_pkg::*;

    logic [width-1:0] mem [FIFO_DEPTH];
    fifo_ptr_t        wr_ptr;
    fifo_ptr_t        rd_ptr;
    fifo_count_t      count;
    logic             full;
    logic             wr_ok;
    logic             rd_ok;

    assign full        = (count == FIFO_DEPTH);
    assign empty       = (count == '0);
    assign almost_full = (count >= PROG_THRESH);

    // Reads on an empty FIFO are dropped here
    assign wr_ok = wr_en & ~full;
    assign rd_ok = rd_en & ~empty;

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_ok;
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and read data
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
        if (rd_ok) begin
            dout <= mem[rd_ptr];
        end
    end

    // Upstream must respect almost_full, so a full FIFO never sees a write
    a_no_write_when_full : assert property (
        @(posedge ap_clk) disable iff (!rst_n) wr_en |-> !full
    );

endmodule

`default_nettype wire

// File: hdl/response_admit.sv
// Response class and window filter
`timescale 1ns/1ps
`default_nettype none

module response_admit #(
    parameter filter_cfg_pkg::seq_index_t seq_base = '0
) (
    input  wire logic                        ap_clk,
    input  wire logic                        rst_n,
    input  wire logic                        resp_valid,
    input  wire filter_cfg_pkg::mem_packet_t resp_packet,
    output logic                             push,
    output filter_cfg_pkg::mem_packet_t      push_packet
);
    import filter_cfg_pkg::*;

    logic        valid_q;
    mem_packet_t packet_q;
    seq_index_t  seq_idx;
    logic        is_setup;
    logic        in_window;

    // ----------------------------------------
    // Input register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= resp_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        packet_q <= resp_packet;
    end

    // Class and window test
    assign seq_idx   = seq_index_of(packet_q);
    assign is_setup  = (packet_q.setup_class == CLASS_CU_SETUP) ||
                       (packet_q.setup_class == CLASS_ENGINE_SETUP);
    assign in_window = (seq_idx >= seq_base) && (seq_idx < seq_base + CFG_WORDS);

    assign push        = valid_q & is_setup & in_window;
    assign push_packet = packet_q;

    // Data traffic seen at the input one cycle earlier never reaches the FIFO
    a_setup_only : assert property (
        @(posedge ap_clk) disable iff (!rst_n)
        push |-> $past(resp_packet.setup_class) inside {CLASS_CU_SETUP, CLASS_ENGINE_SETUP}
    );

endmodule

`default_nettype wire

// File: hdl/cfg_word_sequencer.sv
// Configuration word tracker and decoder
`timescale 1ns/1ps
`default_nettype none

module cfg_word_sequencer #(
    parameter filter_cfg_pkg::seq_index_t seq_base = '0
) (
    input  wire logic                        ap_clk,
    input  wire logic                        rst_n,
    input  wire logic                        resp_empty,
    input  wire logic                        cfg_almost_full,
    output logic                             pop,
    input  wire logic                        word_valid,
    input  wire filter_cfg_pkg::mem_packet_t word,
    output logic                             rec_push,
    output filter_cfg_pkg::filter_cond_cfg_t rec
);
    import filter_cfg_pkg::*;

    logic [CFG_WORDS-1:0] slot;
    logic                 word_valid_q;
    mem_packet_t          word_q;
    logic                 done;

    // Hold off while a finished record goes out
    assign pop      = ~resp_empty & ~cfg_almost_full & ~done;
    assign rec_push = done;

    // ----------------------------------------
    // One-hot slot tracker
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            slot         <= '0;
            word_valid_q <= 1'b0;
            done         <= 1'b0;
        end else begin
            word_valid_q <= word_valid;
            done         <= word_valid_q & slot[CFG_WORDS-1];
            if (word_valid) begin
                // Base word restarts the record
                if (seq_index_of(word) == seq_base) begin
                    slot <= CFG_WORDS'(1);
                end else begin
                    slot <= slot << 1;
                end
            end else if (done && slot[CFG_WORDS-1]) begin
                slot <= '0;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        word_q <= word;
    end

    // ----------------------------------------
    // Field decode
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (word_valid_q) begin
            case (slot)
                8'b0000_0001: rec.filter_op   <= filter_op_t'(word_q.data[2:0]);
                8'b0000_0010: rec.filter_mask <= word_q.data[NUM_FIELDS-1:0];
                8'b0000_0100: rec.const_mask  <= word_q.data[NUM_FIELDS-1:0];
                8'b0000_1000: rec.const_value <= word_q.data;
                8'b0001_0000: rec.ops_mask    <= word_q.data[NUM_FIELDS*NUM_FIELDS-1:0];
                8'b0010_0000: begin
                    rec.break_flag       <= word_q.data[0];
                    rec.continue_flag    <= word_q.data[1];
                    rec.ternary_flag     <= word_q.data[2];
                    rec.conditional_flag <= word_q.data[3];
                end
                8'b0100_0000: begin
                    rec.if_route.cu     <= word_q.data[3:0];
                    rec.if_route.bundle <= word_q.data[7:4];
                    rec.if_route.lane   <= word_q.data[11:8];
                    rec.if_route.buffer <= word_q.data[15:12];
                end
                8'b1000_0000: begin
                    rec.else_route.cu     <= word_q.data[3:0];
                    rec.else_route.bundle <= word_q.data[7:4];
                    rec.else_route.lane   <= word_q.data[11:8];
                    rec.else_route.buffer <= word_q.data[15:12];
                end
                default: rec <= rec;
            endcase
        end
    end

    a_slot_onehot : assert property (
        @(posedge ap_clk) disable iff (!rst_n) $onehot0(slot)
    );

endmodule

`default_nettype wire

// File: hdl/filter_cond_config_loader.sv
// Filter condition configuration loader
`timescale 1ns/1ps
`default_nettype none

module filter_cond_config_loader #(
    parameter int unsigned window_index = 0
) (
    input  wire logic                        ap_clk,
    input  wire logic                        rst_n,
    input  wire logic                        resp_valid,
    input  wire filter_cfg_pkg::mem_packet_t resp_packet,
    output logic                             resp_almost_full,
    input  wire logic                        cfg_ready,
    output logic                             cfg_valid,
    output filter_cfg_pkg::filter_cond_cfg_t cfg_record
);
    import filter_cfg_pkg::*;

    logic             admit_push;
    mem_packet_t      admit_packet;
    logic             seq_pop;
    logic             resp_word_valid;
    mem_packet_t      resp_word;
    logic             resp_empty;
    logic             rec_push;
    filter_cond_cfg_t rec;
    logic             cfg_almost_full;

    // ----------------------------------------
    // Admission
    // ----------------------------------------
    response_admit #(
        .seq_base(seq_index_t'(window_index * CFG_WORDS))
    ) i_admit (
        .ap_clk     (ap_clk),
        .rst_n      (rst_n),
        .resp_valid (resp_valid),
        .resp_packet(resp_packet),
        .push       (admit_push),
        .push_packet(admit_packet)
    );

    // Response FIFO
    cfg_fifo_sync #(
        .width($bits(mem_packet_t))
    ) i_resp_fifo (
        .ap_clk     (ap_clk),
        .rst_n      (rst_n),
        .wr_en      (admit_push),
        .din        (admit_packet),
        .rd_en      (seq_pop),
        .dout       (resp_word),
        .rd_valid   (resp_word_valid),
        .empty      (resp_empty),
        .almost_full(resp_almost_full)
    );

    // ----------------------------------------
    // Decode
    // ----------------------------------------
    cfg_word_sequencer #(
        .seq_base(seq_index_t'(window_index * CFG_WORDS))
    ) i_sequencer (
        .ap_clk         (ap_clk),
        .rst_n          (rst_n),
        .resp_empty     (resp_empty),
        .cfg_almost_full(cfg_almost_full),
        .pop            (seq_pop),
        .word_valid     (resp_word_valid),
        .word           (resp_word),
        .rec_push       (rec_push),
        .rec            (rec)
    );

    // Configuration FIFO, popped directly by the consumer
    cfg_fifo_sync #(
        .width($bits(filter_cond_cfg_t))
    ) i_cfg_fifo (
        .ap_clk     (ap_clk),
        .rst_n      (rst_n),
        .wr_en      (rec_push),
        .din        (rec),
        .rd_en      (cfg_ready),
        .dout       (cfg_record),
        .rd_valid   (cfg_valid),
        .empty      (),
        .almost_full(cfg_almost_full)
    );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real period_ns    = 4.0,
    parameter int  reset_cycles = 10
) (
    output logic ap_clk,
    output logic rst_n
);

    initial begin
        ap_clk = 1'b0;
        forever #(period_ns / 2.0) ap_clk = ~ap_clk;
    end

    // Release lands just after an edge, like the other stimulus
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge ap_clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: test/tb_filter_cond_config_loader.sv
// Filter condition loader testbench
`timescale 1ns/1ps
`default_nettype none

module tb_filter_cond_config_loader;
    import filter_cfg_pkg::*;

    localparam int window_index   = 1;
    localparam int seq_base       = window_index * CFG_WORDS;
    localparam int reset_cycles   = 10;
    // Words sent: decode, admission, shifted, restart, back-pressure
    localparam int stim_words     = 8 + 16 + 8 + 12 + 24;
    localparam int hold_cycles    = 40;
    localparam int stim_cycles    = reset_cycles + stim_words + hold_cycles;
    localparam int timeout_cycles = 2 * stim_cycles + 200;
    localparam int drain_limit    = 60;

    logic             ap_clk;
    logic             rst_n;
    logic             resp_valid;
    mem_packet_t      resp_packet;
    logic             resp_almost_full;
    logic             cfg_ready;
    logic             cfg_valid;
    filter_cond_cfg_t cfg_record;

    logic [31:0]      rng_state = 32'h92bc_6bfa;
    data_word_t       run_words [CFG_WORDS];
    filter_cond_cfg_t exp_q [$];
    filter_cond_cfg_t cur_exp;
    logic             cur_has = 1'b0;
    int unsigned      cycle_count = 0;

    tb_clock_gen #(
        .period_ns   (4.0),
        .reset_cycles(reset_cycles)
    ) i_clock_gen (
        .ap_clk(ap_clk),
        .rst_n (rst_n)
    );

    filter_cond_config_loader #(
        .window_index(window_index)
    ) i_dut (
        .ap_clk          (ap_clk),
        .rst_n           (rst_n),
        .resp_valid      (resp_valid),
        .resp_packet     (resp_packet),
        .resp_almost_full(resp_almost_full),
        .cfg_ready       (cfg_ready),
        .cfg_valid       (cfg_valid),
        .cfg_record      (cfg_record)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ----------------------------------------
    // Reference decode of one eight-word run
    // ----------------------------------------
    function automatic filter_cond_cfg_t expected_record();
        filter_cond_cfg_t r;
        r.filter_op         = filter_op_t'(run_words[0][2:0]);
        r.filter_mask       = run_words[1][3:0];
        r.const_mask        = run_words[2][3:0];
        r.const_value       = run_words[3];
        r.ops_mask          = run_words[4][15:0];
        r.break_flag        = run_words[5][0];
        r.continue_flag     = run_words[5][1];
        r.ternary_flag      = run_words[5][2];
        r.conditional_flag  = run_words[5][3];
        r.if_route.cu       = run_words[6][3:0];
        r.if_route.bundle   = run_words[6][7:4];
        r.if_route.lane     = run_words[6][11:8];
        r.if_route.buffer   = run_words[6][15:12];
        r.else_route.cu     = run_words[7][3:0];
        r.else_route.bundle = run_words[7][7:4];
        r.else_route.lane   = run_words[7][11:8];
        r.else_route.buffer = run_words[7][15:12];
        return r;
    endfunction

    task automatic fill_random_run();
        for (int i = 0; i < CFG_WORDS; i++) begin
            rng_state    = xorshift32(rng_state);
            run_words[i] = rng_state;
        end
    endtask

    // One packet per cycle, paused while the response FIFO is almost full
    task automatic send_word(input setup_class_t cls, input int idx,
                             input int shamt, input data_word_t dat);
        while (resp_almost_full) begin
            resp_valid = 1'b0;
            @(posedge ap_clk);
            #1;
        end
        resp_valid  = 1'b1;
        resp_packet = '{setup_class: cls, offset: seq_index_t'(idx << shamt),
                        shift_amount: shamt[SHIFT_W-1:0], data: dat};
        @(posedge ap_clk);
        #1;
        resp_valid = 1'b0;
    endtask

    task automatic send_slot(input setup_class_t cls, input int shamt, input int slot);
        send_word(cls, seq_base + slot, shamt, run_words[slot]);
    endtask

    task automatic send_full_run(input setup_class_t cls, input int shamt);
        fill_random_run();
        exp_q.push_back(expected_record());
        for (int s = 0; s < CFG_WORDS; s++) begin
            send_slot(cls, shamt, s);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_limit) begin
            @(posedge ap_clk);
            #1;
            waited++;
        end
    endtask

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
    end

    // cfg_valid is stable here and matches what the next edge samples
    always @(negedge ap_clk) begin
        if (rst_n && cfg_valid) begin
            if (exp_q.size() > 0) begin
                cur_exp = exp_q.pop_front();
                cur_has = 1'b1;
            end else begin
                cur_has = 1'b0;
            end
        end
    end

    a_reset_valid_low : assert property (@(posedge ap_clk)
        ((cycle_count > 0) && (!rst_n || $past(!rst_n))) |-> !cfg_valid)
    else abort_run($sformatf("ERR time=%0t signal=cfg_valid expected=0 actual=%b",
                             $time, $sampled(cfg_valid)));

    a_reset_afull_low : assert property (@(posedge ap_clk)
        ((cycle_count > 0) && (!rst_n || $past(!rst_n))) |-> !resp_almost_full)
    else abort_run($sformatf("ERR time=%0t signal=resp_almost_full expected=0 actual=%b",
                             $time, $sampled(resp_almost_full)));

    a_record_expected : assert property (@(posedge ap_clk) disable iff (!rst_n)
        cfg_valid |-> cur_has)
    else abort_run($sformatf("Unexpected record at %0t with no record outstanding", $time));

    a_record_match : assert property (@(posedge ap_clk) disable iff (!rst_n)
        (cfg_valid && cur_has) |-> (cfg_record == cur_exp))
    else abort_run($sformatf("ERR time=%0t signal=cfg_record expected=%h actual=%h",
                             $time, cur_exp, $sampled(cfg_record)));

    a_quiet_when_stalled : assert property (@(posedge ap_clk) disable iff (!rst_n)
        !cfg_ready |=> !cfg_valid)
    else abort_run($sformatf("ERR time=%0t signal=cfg_valid expected=0 actual=%b",
                             $time, $sampled(cfg_valid)));

    initial begin
        wait (cycle_count >= timeout_cycles);
        abort_run($sformatf("Timeout after %0d cycles, records stopped arriving", cycle_count));
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        resp_valid  = 1'b0;
        resp_packet = '0;
        cfg_ready   = 1'b1;
        wait (rst_n === 1'b1);
        @(posedge ap_clk);
        #1;

        // Plain in-order run
        send_full_run(CLASS_CU_SETUP, 0);
        wait_drain();

        // Valid run with foreign class and out-of-window words between its words
        fill_random_run();
        exp_q.push_back(expected_record());
        for (int s = 0; s < CFG_WORDS; s++) begin
            send_slot(CLASS_CU_SETUP, 0, s);
            rng_state = xorshift32(rng_state);
            case (s % 4)
                0:       send_word(CLASS_DATA, seq_base + s, 0, rng_state);
                1:       send_word(CLASS_CU_SETUP, seq_base - 1, 0, rng_state);
                2:       send_word(CLASS_ENGINE_SETUP, seq_base + CFG_WORDS, 0, rng_state);
                default: send_word(CLASS_NONE, seq_base, 0, rng_state);
            endcase
        end
        wait_drain();

        // Offsets scaled by four, shift of two
        send_full_run(CLASS_ENGINE_SETUP, 2);
        wait_drain();

        // Broken run, then a new base word starts over
        fill_random_run();
        for (int s = 0; s < 4; s++) begin
            send_slot(CLASS_CU_SETUP, 0, s);
        end
        send_full_run(CLASS_CU_SETUP, 0);
        wait_drain();

        // Consumer stalled across three runs
        cfg_ready = 1'b0;
        for (int r = 0; r < 3; r++) begin
            send_full_run(CLASS_ENGINE_SETUP, 0);
        end
        repeat (hold_cycles) @(posedge ap_clk);
        #1;
        cfg_ready = 1'b1;
        wait_drain();

        repeat (4) @(posedge ap_clk);
        if (exp_q.size() != 0) begin
            abort_run($sformatf("Missing records: %0d never appeared", exp_q.size()));
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: flist.f
hdl/filter_cfg_pkg.sv
hdl/cfg_fifo_sync.sv
hdl/response_admit.sv
hdl/cfg_word_sequencer.sv
hdl/filter_cond_config_loader.sv
test/tb_clock_gen.sv
test/tb_filter_cond_config_loader.sv
